// ==== tb.f ====
design/busPkg.sv
design/samplePkg.sv
design/busRegs.sv
design/adcReclock.sv
design/dacChannel.sv
design/stcDacTop.sv
test/stcDac_asserts.sv
test/stcDacTb.sv

// ==== Makefile ====
# Verilator build and run for the DAC sample path testbench

VERILATOR  = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/10ps
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/10ps
TOP        = stcDacTb
FILELIST   = tb.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Simulation failed
PASS_MSG   = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL: run ended without a final message, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/stcDacTb.sv ====
`timescale 1ns/10ps

module stcDacTb;

    import busPkg::*;
    import samplePkg::*;

    // ****************************************
    // Stimulus table format
    // ****************************************

    localparam logic [1:0] opWrite    = 2'd0;
    localparam logic [1:0] opRead     = 2'd1;
    localparam logic [1:0] opBurst    = 2'd2;
    localparam logic [1:0] opDacCheck = 2'd3;

    // Marks a dac1 expectation that tracks the ADC model
    localparam busDataT followAdc = 16'hFFFF;

    // Test levels for channel 1
    localparam levelT levelA = 16'hA5C3;
    localparam levelT levelB = 16'h3F16;

    // Burst and check entries use data as a cycle count
    typedef struct packed {
        logic [1:0] op;
        logic       ovf;
        busAddrT    addr;
        busDataT    data;
        busDataT    expVal;
    } entryT;

    logic       clk;
    logic       rstN;
    logic       cs;
    logic       wr;
    logic       rd;
    busAddrT    addr;
    busDataT    wrData;
    busDataT    rdData;
    adcWordT    adc;
    logic       adcOverflow;
    dacWordT    dac0Data;
    dacWordT    dac1Data;

    entryT      stimTable[$];
    // ADC words of the last three falling edges with the oldest first
    adcWordT    adcHist[$];
    adcWordT    expectedAdc;
    integer     seed;
    int         errorCount;
    int         checkCount;

    stcDacTop DUT (
        .clk         (clk),
        .rstN        (rstN),
        .cs          (cs),
        .wr          (wr),
        .rd          (rd),
        .addr        (addr),
        .wrData      (wrData),
        .rdData      (rdData),
        .adc         (adc),
        .adcOverflow (adcOverflow),
        .dac0Data    (dac0Data),
        .dac1Data    (dac1Data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ****************************************
    // Helpers
    // ****************************************

    // Level mode output with the sign flipped and the top 14 bits kept
    function automatic dacWordT levelToDac(input levelT level);
        return {~level[15], level[14:2]};
    endfunction

    task automatic compareValue(input string what, input busDataT got, input busDataT want);
        checkCount++;
        assert (got === want) else begin
            $display("Mismatch at %0t ns: %s got 0x%04h, expected 0x%04h",
                     $time, what, got, want);
            errorCount++;
        end
    endtask

    // Advance to the next falling edge and drive the ADC pins
    task automatic nextCycle(input adcWordT word, input logic ovf);
        @(negedge clk);
        expectedAdc = adcHist.pop_front();
        adc         = word;
        adcOverflow = ovf;
        adcHist.push_back(word);
    endtask

    task automatic busWrite(input busAddrT a, input busDataT d);
        nextCycle(adc, 1'b0);
        cs     = 1'b1;
        wr     = 1'b1;
        addr   = a;
        wrData = d;
        nextCycle(adc, 1'b0);
        compareValue("rdData while rd is low", rdData, 16'h0000);
        cs = 1'b0;
        wr = 1'b0;
    endtask

    task automatic busRead(input busAddrT a, input busDataT want);
        nextCycle(adc, 1'b0);
        cs   = 1'b1;
        rd   = 1'b1;
        addr = a;
        nextCycle(adc, 1'b0);
        compareValue($sformatf("read at 0x%03h", a), rdData, want);
        cs = 1'b0;
        rd = 1'b0;
    endtask

    task automatic checkOutputs(input busDataT dac1Want);
        compareValue("dac0Data", {2'b00, dac0Data}, {2'b00, expectedAdc});
        if (dac1Want == followAdc) begin
            compareValue("dac1Data", {2'b00, dac1Data}, {2'b00, expectedAdc});
        end
        else begin
            compareValue("dac1Data", {2'b00, dac1Data}, dac1Want);
        end
    endtask

    task automatic runEntry(input entryT e);
        int         n;
        logic [31:0] randVal;
        case (e.op)
            opWrite: busWrite(e.addr, e.data);
            opRead:  busRead(e.addr, e.expVal);
            opBurst: begin
                for (n = 0; n < int'(e.data); n++) begin
                    randVal = $random(seed);
                    nextCycle(randVal[13:0], e.ovf);
                    checkOutputs(e.expVal);
                end
            end
            default: begin
                // Hold the ADC, then look at both outputs once
                for (n = 0; n < int'(e.data); n++) begin
                    nextCycle(adc, 1'b0);
                end
                checkOutputs(e.expVal);
            end
        endcase
    endtask

    task automatic addEntry(input logic [1:0] op, input logic ovf, input busAddrT a,
                            input busDataT d, input busDataT e);
        entryT entry;
        entry.op     = op;
        entry.ovf    = ovf;
        entry.addr   = a;
        entry.data   = d;
        entry.expVal = e;
        stimTable.push_back(entry);
    endtask

    // ****************************************
    // Stimulus table
    // ****************************************

    task automatic buildTable();
        // Reset state and version
        addEntry(opDacCheck, 1'b0, 13'h000, 16'd0, 16'h2000);
        addEntry(opDacCheck, 1'b0, 13'h000, 16'd1, 16'h2000);
        addEntry(opRead, 1'b0, regAddrVersion, 16'h0000, 16'd530);
        addEntry(opRead, 1'b0, regAddrVersion + 13'h2, 16'h0000, 16'h0000);
        addEntry(opWrite, 1'b0, regAddrVersion, 16'h1234, 16'h0000);
        addEntry(opRead, 1'b0, regAddrVersion, 16'h0000, 16'd530);
        // ADC path on both channels
        addEntry(opBurst, 1'b0, 13'h000, 16'd24, followAdc);
        // Test level on channel 1
        addEntry(opWrite, 1'b0, regAddrDac1Source, {12'h000, dacSrcLevel}, 16'h0000);
        addEntry(opWrite, 1'b0, regAddrTestLevel, levelA, 16'h0000);
        addEntry(opDacCheck, 1'b0, 13'h000, 16'd2, {2'b00, levelToDac(levelA)});
        addEntry(opBurst, 1'b0, 13'h000, 16'd16, {2'b00, levelToDac(levelA)});
        // Readback, high halves and unmapped space
        addEntry(opRead, 1'b0, regAddrDac0Source, 16'h0000, 16'h0000);
        addEntry(opRead, 1'b0, regAddrDac1Source, 16'h0000, 16'h0001);
        addEntry(opRead, 1'b0, regAddrTestLevel, 16'h0000, levelA);
        addEntry(opRead, 1'b0, regAddrTestLevel + 13'h2, 16'h0000, 16'h0000);
        addEntry(opRead, 1'b0, regAddrDac1Source + 13'h2, 16'h0000, 16'h0000);
        addEntry(opRead, 1'b0, 13'h014, 16'h0000, 16'h0000);
        addEntry(opRead, 1'b0, 13'h1F0, 16'h0000, 16'h0000);
        addEntry(opWrite, 1'b0, regAddrTestLevel + 13'h2, 16'hFFFF, 16'h0000);
        addEntry(opRead, 1'b0, regAddrTestLevel, 16'h0000, levelA);
        addEntry(opRead, 1'b0, regAddrTestLevel + 13'h2, 16'h0000, 16'h0000);
        addEntry(opWrite, 1'b0, regAddrTestLevel, levelB, 16'h0000);
        addEntry(opDacCheck, 1'b0, 13'h000, 16'd2, {2'b00, levelToDac(levelB)});
        // Unassigned source code behaves as the ADC
        addEntry(opWrite, 1'b0, regAddrDac0Source, 16'h000F, 16'h0000);
        addEntry(opBurst, 1'b0, 13'h000, 16'd12, {2'b00, levelToDac(levelB)});
        addEntry(opRead, 1'b0, regAddrDac0Source, 16'h0000, 16'h000F);
        // Overflow count and clear
        addEntry(opRead, 1'b0, regAddrOverflowCount, 16'h0000, 16'h0000);
        addEntry(opBurst, 1'b1, 13'h000, 16'd5, {2'b00, levelToDac(levelB)});
        addEntry(opDacCheck, 1'b0, 13'h000, 16'd3, {2'b00, levelToDac(levelB)});
        addEntry(opRead, 1'b0, regAddrOverflowCount, 16'h0000, 16'd5);
        addEntry(opWrite, 1'b0, regAddrOverflowCount, 16'h5A5A, 16'h0000);
        addEntry(opRead, 1'b0, regAddrOverflowCount, 16'h0000, 16'h0000);
        addEntry(opBurst, 1'b1, 13'h000, 16'd7, {2'b00, levelToDac(levelB)});
        addEntry(opDacCheck, 1'b0, 13'h000, 16'd3, {2'b00, levelToDac(levelB)});
        addEntry(opRead, 1'b0, regAddrOverflowCount, 16'h0000, 16'd7);
        // Channel 1 back on the ADC
        addEntry(opWrite, 1'b0, regAddrDac1Source, {12'h000, dacSrcAdc}, 16'h0000);
        addEntry(opDacCheck, 1'b0, 13'h000, 16'd2, followAdc);
        addEntry(opBurst, 1'b0, 13'h000, 16'd20, followAdc);
    endtask

    // ****************************************
    // Main sequence
    // ****************************************

    initial begin
        int cycle;
        int idx;
        rstN        = 1'b0;
        cs          = 1'b0;
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        wrData      = '0;
        adc         = 14'h2000;
        adcOverflow = 1'b0;
        seed        = 32'hfdae0c7c;
        errorCount  = 0;
        checkCount  = 0;
        expectedAdc = 14'h2000;
        for (cycle = 0; cycle < 3; cycle++) begin
            adcHist.push_back(14'h2000);
        end
        buildTable();

        for (cycle = 0; cycle < 8; cycle++) begin
            @(negedge clk);
        end
        rstN = 1'b1;

        for (idx = 0; idx < stimTable.size(); idx++) begin
            runEntry(stimTable[idx]);
        end

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== test/stcDac_asserts.sv ====
`timescale 1ns/10ps

module stcDacAsserts (
    input  logic                    clk,
    input  logic                    rstN,
    input  samplePkg::adcWordT      adc,
    input  samplePkg::dacSourceT    dac0Source,
    input  samplePkg::dacWordT      dac0Data,
    input  samplePkg::dacWordT      dac1Data,
    input  busPkg::busDataT         rdData,
    input  logic                    overflowClear
);

    import samplePkg::*;

    // ****************************************
    // Timing rules
    // ****************************************

    // Clear is a strobe, never two cycles long
    property clearSingleCycle;
        @(posedge clk) disable iff (!rstN)
        !(overflowClear && $past(overflowClear));
    endproperty

    // Source register samples the select two edges back
    property adcToDac0;
        @(posedge clk) disable iff (!rstN)
        ($past(rstN, 3) && ($past(dac0Source, 2) != dacSrcLevel))
            |-> (dac0Data == $past(adc, 3));
    endproperty

    property outputsKnown;
        @(posedge clk) disable iff (!rstN)
        !$isunknown({dac0Data, dac1Data, rdData});
    endproperty

    clearPulseCheck: assert property (clearSingleCycle)
        else $error("overflowClear was high for two cycles in a row");

    adcLatencyCheck: assert property (adcToDac0)
        else $error("dac0Data does not match the adc word from 3 cycles earlier");

    knownOutputCheck: assert property (outputsKnown)
        else $error("a DUT output is unknown after reset");

endmodule

bind stcDacTop stcDacAsserts timingChecks (
    .clk           (clk),
    .rstN          (rstN),
    .adc           (adc),
    .dac0Source    (dac0Source),
    .dac0Data      (dac0Data),
    .dac1Data      (dac1Data),
    .rdData        (rdData),
    .overflowClear (overflowClear)
);

// ==== design/stcDacTop.sv ====
`timescale 1ns/10ps

module stcDacTop (
    input  logic                clk,
    input  logic                rstN,

    // Register bus
    input  logic                cs,
    input  logic                wr,
    input  logic                rd,
    input  busPkg::busAddrT     addr,
    input  busPkg::busDataT     wrData,
    output busPkg::busDataT     rdData,

    // ADC interface
    input  samplePkg::adcWordT  adc,
    input  logic                adcOverflow,

    // DAC datapaths
    output samplePkg::dacWordT  dac0Data,
    output samplePkg::dacWordT  dac1Data
);

    import samplePkg::*;

    sampleT     adcSample;
    countT      overflowCount;
    dacSourceT  dac0Source;
    dacSourceT  dac1Source;
    levelT      testLevel;
    logic       overflowClear;

    // ****************************************
    // Register block
    // ****************************************

    busRegs regs (
        .clk           (clk),
        .rstN          (rstN),
        .cs            (cs),
        .wr            (wr),
        .rd            (rd),
        .addr          (addr),
        .wrData        (wrData),
        .rdData        (rdData),
        .overflowCount (overflowCount),
        .dac0Source    (dac0Source),
        .dac1Source    (dac1Source),
        .testLevel     (testLevel),
        .overflowClear (overflowClear)
    );

    // ****************************************
    // ADC reclock
    // ****************************************

    adcReclock reclock (
        .clk           (clk),
        .rstN          (rstN),
        .adc           (adc),
        .adcOverflow   (adcOverflow),
        .overflowClear (overflowClear),
        .adcSample     (adcSample),
        .overflowCount (overflowCount)
    );

    // ****************************************
    // DAC channels
    // ****************************************

    dacChannel dacCh0 (
        .clk       (clk),
        .rstN      (rstN),
        .adcSample (adcSample),
        .testLevel (testLevel),
        .source    (dac0Source),
        .dacData   (dac0Data)
    );

    dacChannel dacCh1 (
        .clk       (clk),
        .rstN      (rstN),
        .adcSample (adcSample),
        .testLevel (testLevel),
        .source    (dac1Source),
        .dacData   (dac1Data)
    );

endmodule

// ==== design/dacChannel.sv ====
`timescale 1ns/10ps

module dacChannel (
    input  logic                    clk,
    input  logic                    rstN,

    // Candidate sources
    input  samplePkg::sampleT       adcSample,
    input  samplePkg::levelT        testLevel,

    // Source select from the register block
    input  samplePkg::dacSourceT    source,

    // Offset-binary word to the DAC pins
    output samplePkg::dacWordT      dacData
);

    import samplePkg::*;

    sampleT     selSample;
    sampleT     srcSample;

    // ****************************************
    // Source select
    // ****************************************

    always_comb begin
        case (source)
            dacSrcAdc:   selSample = adcSample;
            // Level is padded below to the sample width
            dacSrcLevel: selSample = {testLevel, 2'b00};
            // Unassigned codes fall back to the ADC
            default:     selSample = adcSample;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            srcSample <= '0;
        end
        else begin
            srcSample <= selSample;
        end
    end

    // ****************************************
    // DAC output formatting
    // ****************************************

    // Top 14 bits with the sign flipped back to offset binary
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dacData <= 14'h2000;
        end
        else begin
            dacData <= {~srcSample[17], srcSample[16:4]};
        end
    end

endmodule

// ==== design/adcReclock.sv ====
`timescale 1ns/10ps

module adcReclock (
    input  logic                clk,
    input  logic                rstN,

    // ADC pins
    input  samplePkg::adcWordT  adc,
    input  logic                adcOverflow,

    // Count clear from the register block
    input  logic                overflowClear,

    output samplePkg::sampleT   adcSample,
    output samplePkg::countT    overflowCount
);

    import samplePkg::*;

    adcWordT    adcReg;
    logic       overflowReg;

    // ****************************************
    // Input capture
    // ****************************************

    // Capture starts at midscale so the sample reads as signed zero
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            adcReg      <= 14'h2000;
            overflowReg <= 1'b0;
        end
        else begin
            adcReg      <= adc;
            overflowReg <= adcOverflow;
        end
    end

    // Flip the MSB for two's complement, then left-justify to 18 bits
    assign adcSample = {~adcReg[13], adcReg[12:0], 4'b0000};

    // ****************************************
    // Overflow counter
    // ****************************************

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            overflowCount <= '0;
        end
        else if (overflowClear) begin
            overflowCount <= '0;
        end
        else if (overflowReg && (overflowCount != '1)) begin
            // Holds at full scale
            overflowCount <= overflowCount + countT'(1);
        end
    end

endmodule

// ==== design/busRegs.sv ====
`timescale 1ns/10ps

module busRegs (
    input  logic                clk,
    input  logic                rstN,

    // Host side of the strobed register bus
    input  logic                cs,
    input  logic                wr,
    input  logic                rd,
    input  busPkg::busAddrT     addr,
    input  busPkg::busDataT     wrData,
    output busPkg::busDataT     rdData,

    // Status from the ADC reclock
    input  samplePkg::countT    overflowCount,

    // Control to the sample path
    output samplePkg::dacSourceT dac0Source,
    output samplePkg::dacSourceT dac1Source,
    output samplePkg::levelT    testLevel,
    output logic                overflowClear
);

    import busPkg::*;
    import samplePkg::*;

    // Address of the 32-bit register holding the addressed half
    busAddrT        regWordAddr;
    logic           highHalf;
    logic           wrLow;
    logic   [31:0]  regValue;

    assign regWordAddr = {addr[12:2], 2'b00};
    assign highHalf    = addr[1];

    // High halves have no storage, so only low-half writes land
    assign wrLow = cs && wr && !highHalf;

    // ****************************************
    // Write decode
    // ****************************************

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dac0Source <= dacSrcAdc;
            dac1Source <= dacSrcAdc;
            testLevel  <= '0;
        end
        else if (wrLow) begin
            case (regWordAddr)
                regAddrDac0Source: dac0Source <= wrData[3:0];
                regAddrDac1Source: dac1Source <= wrData[3:0];
                regAddrTestLevel:  testLevel  <= wrData;
                default: begin
                    // Version and count are read-only here
                end
            endcase
        end
    end

    // One-cycle clear, high in the cycle after the write edge
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            overflowClear <= 1'b0;
        end
        else begin
            overflowClear <= wrLow && (regWordAddr == regAddrOverflowCount);
        end
    end

    // ****************************************
    // Read mux
    // ****************************************

    always_comb begin
        case (regWordAddr)
            regAddrVersion:       regValue = {16'h0000, versionNumber};
            regAddrDac0Source:    regValue = {28'h0000000, dac0Source};
            regAddrDac1Source:    regValue = {28'h0000000, dac1Source};
            regAddrTestLevel:     regValue = {16'h0000, testLevel};
            regAddrOverflowCount: regValue = {16'h0000, overflowCount};
            default:              regValue = 32'h00000000;
        endcase
    end

    // Bit 1 of the address picks the half, bus idles at zero
    always_comb begin
        if (cs && rd) begin
            if (highHalf) begin
                rdData = regValue[31:16];
            end
            else begin
                rdData = regValue[15:0];
            end
        end
        else begin
            rdData = '0;
        end
    end

endmodule

// ==== design/samplePkg.sv ====
package samplePkg;

    // ****************************************
    // Sample path widths
    // ****************************************

    // Raw offset-binary word from the ADC
    typedef logic [13:0] adcWordT;

    // Internal sample, two's complement and left-justified
    typedef logic signed [17:0] sampleT;

    // Offset-binary word to the DAC
    typedef logic [13:0] dacWordT;

    // Test level written by software, two's complement
    typedef logic [15:0] levelT;

    // Saturating ADC overflow count
    typedef logic [15:0] countT;

    // ****************************************
    // DAC source selection
    // ****************************************

    typedef logic [3:0] dacSourceT;

    // Codes not listed here behave as the ADC source
    localparam dacSourceT dacSrcAdc   = 4'd0;
    localparam dacSourceT dacSrcLevel = 4'd1;

endpackage

// ==== design/busPkg.sv ====
package busPkg;

    // ****************************************
    // Register bus widths
    // ****************************************

    // Byte address of the register bus
    typedef logic [12:0] busAddrT;

    // Data is one 16-bit half of a 32-bit register
    typedef logic [15:0] busDataT;

    // ****************************************
    // Register map
    // ****************************************

    // Byte addresses of the 32-bit registers, low half at offset 0
    localparam busAddrT regAddrVersion       = 13'h000;
    localparam busAddrT regAddrDac0Source    = 13'h004;
    localparam busAddrT regAddrDac1Source    = 13'h008;
    localparam busAddrT regAddrTestLevel     = 13'h00C;
    localparam busAddrT regAddrOverflowCount = 13'h010;

    // Build number returned in the low half of the version register
    localparam busDataT versionNumber = 16'd530;

endpackage
